/* source/snes_host_pkg.sv */
// SNES host adapter shared definitions
// bridge address map, timing and colour constants, and the bus structs
// used between the settings bank, stick filter and video stage

package snes_host_pkg;

  //////////////////////////////
  // bridge address map
  //////////////////////////////
  localparam logic [31:0] addr_rom_size         = 32'h0000_0004;
  localparam logic [31:0] addr_rom_type         = 32'h0000_0008;
  localparam logic [31:0] addr_ram_size         = 32'h0000_000C;
  localparam logic [31:0] addr_pal              = 32'h0000_0010;
  localparam logic [31:0] addr_reset            = 32'h0000_0050;
  localparam logic [31:0] addr_cpu_turbo        = 32'h0000_0080;
  localparam logic [31:0] addr_gsu_turbo        = 32'h0000_0084;
  localparam logic [31:0] addr_multitap         = 32'h0000_0100;
  localparam logic [31:0] addr_lightgun         = 32'h0000_0104;
  localparam logic [31:0] addr_aim_speed        = 32'h0000_0108;
  localparam logic [31:0] addr_deadzone         = 32'h0000_010C;
  localparam logic [31:0] addr_square_pixels    = 32'h0000_0200;
  localparam logic [31:0] addr_blend            = 32'h0000_0204;
  localparam logic [31:0] addr_color_correction = 32'h0000_0208;

  //////////////////////////////
  // constants
  //////////////////////////////
  // core reset pulse, kept short
  localparam int reset_pulse_cycles = 32;
  localparam int reset_cnt_w        = 6;
  localparam int stick_center       = 128;
  // per-channel target gains, 1/256 units
  localparam int corr_gain_r = 234;
  localparam int corr_gain_g = 258;
  localparam int corr_gain_b = 304;
  localparam int chan_max    = 255;

  //////////////////////////////
  // bus types
  //////////////////////////////
  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [31:0] data;
  } bridge_wr_t;

  typedef struct packed {
    logic [7:0] rom_type;
    logic [3:0] rom_size;
    logic [3:0] ram_size;
    logic       pal;
  } cart_info_t;

  typedef struct packed {
    logic       cpu_turbo;
    logic       gsu_turbo;
    logic       multitap;
    logic       lightgun;
    logic       lightgun_type;
    logic       mouse;
    logic       blend;
    logic [7:0] aim_speed;
  } core_settings_t;

  typedef struct packed {
    logic       square_pixels;
    logic [7:0] color_correction;
  } video_settings_t;

  typedef struct packed {
    logic [15:0] keys;
    logic [7:0]  stick_x;
    logic [7:0]  stick_y;
  } pad_state_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  // end-of-line control word for the scaler
  typedef struct packed {
    logic [8:0]  pad_hi;
    logic        tall_frame_n;
    logic        square_pixels;
    logic [12:0] pad_lo;
  } ctrl_word_t;

  typedef union packed {
    pixel_t     pixel;
    ctrl_word_t ctrl;
  } video_word_u;

  typedef struct packed {
    logic        vs;
    logic        hs;
    logic        de;
    logic        tall_frame;
    video_word_u rgb;
  } video_in_t;

  typedef struct packed {
    logic        vs;
    logic        hs;
    logic        de;
    video_word_u word;
  } video_out_t;

endpackage

/* source/bridge_settings.sv */
// Bridge settings bank
// decodes host write beats into cartridge info, core and video settings,
// and runs the timed core reset pulse

module bridge_settings
  import snes_host_pkg::*;
(
  input  logic            clk_74a,
  input  logic            pll_core_locked,
  input  bridge_wr_t      bridge_in,
  output cart_info_t      cart_info,
  output core_settings_t  core_settings,
  output video_settings_t video_settings,
  output logic [7:0]      deadzone,
  output logic            core_reset
);

  logic [reset_cnt_w-1:0] reset_cnt;
  logic                   reset_hit;

  assign reset_hit = bridge_in.wr && (bridge_in.addr == addr_reset);

  //////////////////////////////
  // register bank
  //////////////////////////////
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cart_info      <= '0;
      core_settings  <= '0;
      video_settings <= '0;
      deadzone       <= '0;
    end else if (bridge_in.wr) begin
      // unmapped addresses fall through to default
      case (bridge_in.addr)
        addr_rom_size: begin
          cart_info.rom_size <= bridge_in.data[3:0];
        end
        addr_rom_type: begin
          cart_info.rom_type <= bridge_in.data[7:0];
        end
        addr_ram_size: begin
          cart_info.ram_size <= bridge_in.data[3:0];
        end
        addr_pal: begin
          cart_info.pal <= bridge_in.data[0];
        end
        addr_cpu_turbo: begin
          core_settings.cpu_turbo <= bridge_in.data[0];
        end
        addr_gsu_turbo: begin
          core_settings.gsu_turbo <= bridge_in.data[0];
        end
        addr_multitap: begin
          core_settings.multitap <= bridge_in.data[0];
        end
        addr_lightgun: begin
          // gun enable, gun type and mouse share one word
          core_settings.lightgun      <= bridge_in.data[0];
          core_settings.lightgun_type <= bridge_in.data[1];
          core_settings.mouse         <= bridge_in.data[2];
        end
        addr_aim_speed: begin
          core_settings.aim_speed <= bridge_in.data[7:0];
        end
        addr_deadzone: begin
          deadzone <= bridge_in.data[7:0];
        end
        addr_square_pixels: begin
          video_settings.square_pixels <= bridge_in.data[0];
        end
        addr_blend: begin
          core_settings.blend <= bridge_in.data[0];
        end
        addr_color_correction: begin
          video_settings.color_correction <= bridge_in.data[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // core reset pulse
  //////////////////////////////
  // reload on every reset write, so a second write extends the pulse
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (reset_hit) begin
      reset_cnt <= reset_cnt_w'(reset_pulse_cycles);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  assign core_reset = (reset_cnt != '0);

endmodule

/* source/stick_deadzone.sv */
// Player 1 stick deadzone filter
// centres both axes when the stick sits inside the deadzone,
// keys pass straight through, all outputs registered

module stick_deadzone
  import snes_host_pkg::*;
(
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  logic [15:0] cont1_key,
  input  logic [31:0] cont1_joy,
  input  logic [7:0]  deadzone,
  output pad_state_t  pad_state
);

  logic [7:0] joy_x;
  logic [7:0] joy_y;
  logic [7:0] dist_x;
  logic [7:0] dist_y;
  logic [8:0] dist_sum;
  logic       outside;

  // distance of one axis from centre
  function automatic logic [7:0] axis_dist(input logic [7:0] axis);
    if (axis[7]) begin
      return {1'b0, axis[6:0]};
    end
    return 8'd128 - {1'b0, axis[6:0]};
  endfunction

  // left stick only, upper joy bits are the right stick
  assign joy_x    = cont1_joy[7:0];
  assign joy_y    = cont1_joy[15:8];
  assign dist_x   = axis_dist(joy_x);
  assign dist_y   = axis_dist(joy_y);
  assign dist_sum = {1'b0, dist_x} + {1'b0, dist_y};
  assign outside  = dist_sum > {1'b0, deadzone};

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pad_state.keys    <= '0;
      pad_state.stick_x <= 8'(stick_center);
      pad_state.stick_y <= 8'(stick_center);
    end else begin
      pad_state.keys    <= cont1_key;
      pad_state.stick_x <= outside ? joy_x : 8'(stick_center);
      pad_state.stick_y <= outside ? joy_y : 8'(stick_center);
    end
  end

endmodule

/* source/video_color_out.sv */
// Video output stage
// colour-corrects and clamps active pixels, writes the scaler control
// word on the first blank cycle after each active line, delays syncs

module video_color_out
  import snes_host_pkg::*;
(
  input  logic            clk_74a,
  input  logic            pll_core_locked,
  input  video_in_t       video_in,
  input  video_settings_t video_settings,
  output video_out_t      video_out
);

  logic        tall_latched;
  logic        de_q;
  logic        hs_q;
  logic        vs_q;
  video_word_u word_q;
  video_word_u pix_word;
  video_word_u ctrl_word;
  logic        line_end;

  // blend of c and c*gain, weighted by k out of 255
  function automatic logic [7:0] correct_chan(input logic [7:0] c,
                                              input logic [8:0] gain,
                                              input logic [7:0] k);
    logic [17:0] scaled;
    logic [17:0] mix;
    scaled = ({10'd0, c} * {9'd0, gain}) >> 8;
    mix    = {10'd0, c} * {10'd0, 8'd255 - k};
    mix    = (mix + scaled * {10'd0, k}) >> 8;
    if (mix > 18'(chan_max)) begin
      return 8'(chan_max);
    end
    return mix[7:0];
  endfunction

  //////////////////////////////
  // word sources
  //////////////////////////////
  always_comb begin
    pix_word.pixel.r = correct_chan(video_in.rgb.pixel.r, 9'(corr_gain_r),
                                    video_settings.color_correction);
    pix_word.pixel.g = correct_chan(video_in.rgb.pixel.g, 9'(corr_gain_g),
                                    video_settings.color_correction);
    pix_word.pixel.b = correct_chan(video_in.rgb.pixel.b, 9'(corr_gain_b),
                                    video_settings.color_correction);
  end

  always_comb begin
    ctrl_word                    = '0;
    ctrl_word.ctrl.tall_frame_n  = ~tall_latched;
    ctrl_word.ctrl.square_pixels = video_settings.square_pixels;
  end

  // falling edge of de
  assign line_end = !video_in.de && de_q;

  //////////////////////////////
  // control and sync registers
  //////////////////////////////
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      tall_latched <= 1'b0;
      de_q         <= 1'b0;
      hs_q         <= 1'b0;
      vs_q         <= 1'b0;
    end else begin
      de_q <= video_in.de;
      hs_q <= video_in.hs;
      vs_q <= video_in.vs;
      // frame height sampled once per frame at vsync start
      if (video_in.vs && !vs_q) begin
        tall_latched <= video_in.tall_frame;
      end
    end
  end

  // shared output word, holds while blanking
  always_ff @(posedge clk_74a) begin
    if (video_in.de) begin
      word_q <= pix_word;
    end else if (line_end) begin
      word_q <= ctrl_word;
    end
  end

  // field order follows video_out_t
  assign video_out = {vs_q, hs_q, de_q, word_q};

endmodule

/* source/snes_host_top.sv */
// SNES host adapter top level
// ties the bridge settings bank, the player 1 stick filter and the
// video output stage to the host, controller and core video ports

module snes_host_top
  import snes_host_pkg::*;
(
  input  logic           clk_74a,
  input  logic           pll_core_locked,

  // host bridge writes
  input  bridge_wr_t     bridge_in,

  // player 1 controller
  input  logic [15:0]    cont1_key,
  input  logic [31:0]    cont1_joy,

  // video from the core
  input  video_in_t      video_in,

  // to the core
  output cart_info_t     cart_info,
  output core_settings_t core_settings,
  output logic           core_reset,
  output pad_state_t     pad_state,

  // to the scaler
  output video_out_t     video_out
);

  video_settings_t video_settings;
  logic [7:0]      deadzone;

  //////////////////////////////
  // settings and reset pulse
  //////////////////////////////
  bridge_settings u_bridge_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_in      (bridge_in),
    .cart_info      (cart_info),
    .core_settings  (core_settings),
    .video_settings (video_settings),
    .deadzone       (deadzone),
    .core_reset     (core_reset)
  );

  //////////////////////////////
  // controller input
  //////////////////////////////
  stick_deadzone u_stick_deadzone (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cont1_key      (cont1_key),
    .cont1_joy      (cont1_joy),
    .deadzone       (deadzone),
    .pad_state      (pad_state)
  );

  //////////////////////////////
  // video out
  //////////////////////////////
  video_color_out u_video_color_out (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .video_in       (video_in),
    .video_settings (video_settings),
    .video_out      (video_out)
  );

endmodule

/* testbench/snes_host_sva.sv */
// SNES host adapter assertions
// video latency, reset pulse origin and reset state on the top level

module snes_host_sva
  import snes_host_pkg::*;
(
  input logic           clk_74a,
  input logic           pll_core_locked,
  input bridge_wr_t     bridge_in,
  input video_in_t      video_in,
  input logic           core_reset,
  input cart_info_t     cart_info,
  input core_settings_t core_settings,
  input pad_state_t     pad_state,
  input video_out_t     video_out
);

  int fail_count = 0;

  // video control one register behind the core
  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $past(pll_core_locked) |-> video_out.de == $past(video_in.de))
    else begin
      $error("video_out.de is not the previous video_in.de");
      fail_count++;
    end

  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $past(pll_core_locked) |-> video_out.vs == $past(video_in.vs))
    else begin
      $error("video_out.vs is not the previous video_in.vs");
      fail_count++;
    end

  assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(core_reset) |-> $past(bridge_in.wr && bridge_in.addr == addr_reset))
    else begin
      $error("core_reset rose without a reset write");
      fail_count++;
    end

  assert property (@(posedge clk_74a) !pll_core_locked |->
    !core_reset && !video_out.de && !video_out.hs && !video_out.vs &&
    cart_info == '0 && core_settings == '0 && pad_state.keys == '0 &&
    pad_state.stick_x == 8'(stick_center) && pad_state.stick_y == 8'(stick_center))
    else begin
      $error("outputs active during reset");
      fail_count++;
    end

endmodule

bind snes_host_top snes_host_sva u_snes_host_sva (.*);

/* testbench/snes_host_tb.sv */
// SNES host adapter testbench
// directed tests for the settings bank, reset pulse, stick deadzone
// and video output stage, driven with LFSR data under a cycle limit

module snes_host_tb
  import snes_host_pkg::*;
();

  // generous bound on the run length of all tests
  localparam int max_cycles = 4000;
  localparam logic [31:0] lfsr_taps = 32'hB4BC_D35C;

  logic           clk_74a;
  logic           pll_core_locked;
  bridge_wr_t     bridge_in;
  logic [15:0]    cont1_key;
  logic [31:0]    cont1_joy;
  video_in_t      video_in;
  cart_info_t     cart_info;
  core_settings_t core_settings;
  logic           core_reset;
  pad_state_t     pad_state;
  video_out_t     video_out;

  logic [31:0]    lfsr_state;
  int             cycle_count;
  int             err_count;
  int             test_start_errs;
  int             tests_passed;
  int             tests_failed;
  cart_info_t     exp_cart;
  core_settings_t exp_core;

  snes_host_top u_snes_host_top (.*);

  always #5 clk_74a = ~clk_74a;

  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ lfsr_taps;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic write_bridge(input logic [31:0] addr, input logic [31:0] data);
    bridge_in.wr   = 1'b1;
    bridge_in.addr = addr;
    bridge_in.data = data;
    next_cycle();
    bridge_in.wr = 1'b0;
  endtask

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    err_count++;
  endtask

  task automatic begin_test();
    test_start_errs = err_count;
  endtask

  task automatic end_test(input string name);
    if (err_count == test_start_errs) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, err_count - test_start_errs);
      tests_failed++;
    end
  endtask

  //////////////////////////////
  // compare tasks
  //////////////////////////////
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %b got %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_cart_info(input string name, input cart_info_t exp,
                                 input cart_info_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_core_settings(input string name, input core_settings_t exp,
                                     input core_settings_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_pad_state(input string name, input pad_state_t exp,
                                 input pad_state_t act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_video_word(input string name, input video_word_u exp,
                                  input video_word_u act);
    if (act !== exp) begin
      $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  //////////////////////////////
  // reference models
  //////////////////////////////
  function automatic int center_dist(input logic [7:0] a);
    if (a[7]) begin
      return int'(a[6:0]);
    end
    return 128 - int'(a[6:0]);
  endfunction

  function automatic pad_state_t expected_pad(input logic [15:0] keys,
                                              input logic [31:0] joy,
                                              input logic [7:0] dz);
    pad_state_t p;
    int sum;
    sum = center_dist(joy[7:0]) + center_dist(joy[15:8]);
    p.keys    = keys;
    p.stick_x = (sum > int'(dz)) ? joy[7:0] : 8'd128;
    p.stick_y = (sum > int'(dz)) ? joy[15:8] : 8'd128;
    return p;
  endfunction

  function automatic logic [7:0] corrected(input int c, input int g, input int k);
    int v;
    v = (c * (255 - k) + ((c * g) >> 8) * k) >> 8;
    return (v > chan_max) ? 8'(chan_max) : 8'(v);
  endfunction

  task automatic apply_to_model(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      addr_rom_size: exp_cart.rom_size = data[3:0];
      addr_rom_type: exp_cart.rom_type = data[7:0];
      addr_ram_size: exp_cart.ram_size = data[3:0];
      addr_pal: exp_cart.pal = data[0];
      addr_cpu_turbo: exp_core.cpu_turbo = data[0];
      addr_gsu_turbo: exp_core.gsu_turbo = data[0];
      addr_multitap: exp_core.multitap = data[0];
      addr_lightgun: begin
        exp_core.lightgun      = data[0];
        exp_core.lightgun_type = data[1];
        exp_core.mouse         = data[2];
      end
      addr_aim_speed: exp_core.aim_speed = data[7:0];
      addr_blend: exp_core.blend = data[0];
      default: begin
      end
    endcase
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  task automatic test_reset();
    pad_state_t exp_pad;
    begin_test();
    next_cycle();
    exp_pad.keys    = '0;
    exp_pad.stick_x = 8'd128;
    exp_pad.stick_y = 8'd128;
    check_bit("core_reset", 1'b0, core_reset);
    check_bit("video_out.de", 1'b0, video_out.de);
    check_bit("video_out.hs", 1'b0, video_out.hs);
    check_bit("video_out.vs", 1'b0, video_out.vs);
    check_cart_info("cart_info", '0, cart_info);
    check_core_settings("core_settings", '0, core_settings);
    check_pad_state("pad_state", exp_pad, pad_state);
    end_test("reset");
  endtask

  task automatic test_settings();
    logic [31:0] addrs [13];
    logic [31:0] data;
    begin_test();
    addrs = '{addr_rom_size, addr_rom_type, addr_ram_size, addr_pal, addr_cpu_turbo,
              addr_gsu_turbo, addr_multitap, addr_lightgun, addr_aim_speed,
              addr_deadzone, addr_square_pixels, addr_blend, addr_color_correction};
    foreach (addrs[i]) begin
      take_bits(32, data);
      write_bridge(addrs[i], data);
      apply_to_model(addrs[i], data);
      check_cart_info("cart_info", exp_cart, cart_info);
      check_core_settings("core_settings", exp_core, core_settings);
    end
    // gap in the address map
    take_bits(32, data);
    write_bridge(32'h0000_0300, data);
    check_cart_info("cart_info", exp_cart, cart_info);
    check_core_settings("core_settings", exp_core, core_settings);
    end_test("settings map");
  endtask

  task automatic count_pulse(output int n);
    n = 0;
    while (core_reset === 1'b1 && n < 2 * reset_pulse_cycles) begin
      n++;
      next_cycle();
    end
  endtask

  task automatic test_reset_pulse();
    logic [31:0] data;
    int len;
    begin_test();
    take_bits(32, data);
    write_bridge(addr_reset, data);
    count_pulse(len);
    if (len != reset_pulse_cycles) begin
      report_error($sformatf("core_reset pulse lasted %0d cycles, not %0d",
                             len, reset_pulse_cycles));
    end
    write_bridge(addr_reset, data);
    repeat (10) begin
      check_bit("core_reset", 1'b1, core_reset);
      next_cycle();
    end
    // second write restarts the count
    write_bridge(addr_reset, data);
    count_pulse(len);
    if (len != reset_pulse_cycles) begin
      report_error($sformatf("extended core_reset pulse lasted %0d cycles after rewrite",
                             len));
    end
    end_test("reset pulse");
  endtask

  task automatic apply_stick(input logic [15:0] keys, input logic [31:0] joy,
                             input logic [7:0] dz);
    cont1_key = keys;
    cont1_joy = joy;
    next_cycle();
    check_pad_state("pad_state", expected_pad(keys, joy, dz), pad_state);
  endtask

  task automatic test_deadzone();
    logic [31:0] r;
    logic [31:0] j;
    logic [7:0]  dz;
    logic [7:0]  dx;
    logic [7:0]  dy;
    begin_test();
    take_bits(7, r);
    dz = 8'd40 + r[7:0];
    write_bridge(addr_deadzone, {24'd0, dz});
    dx = dz >> 1;
    dy = dz - dx;
    apply_stick(16'hA5C3, {16'hFFFF, 8'h80 | dy, 8'h80 | dx}, dz);
    apply_stick(16'h5A3C, {16'h0000, 8'h80 | (dy + 8'd1), 8'h80 | dx}, dz);
    repeat (8) begin
      take_bits(16, r);
      take_bits(32, j);
      apply_stick(r[15:0], j, dz);
    end
    end_test("deadzone");
  endtask

  task automatic test_color();
    logic [31:0] r;
    logic [7:0]  k;
    video_word_u exp;
    begin_test();
    for (int pass = 0; pass < 3; pass++) begin
      take_bits(8, r);
      k = (pass == 0) ? 8'd0 : (pass == 1) ? 8'd255 : r[7:0];
      write_bridge(addr_color_correction, {24'd0, k});
      for (int i = 0; i < 6; i++) begin
        // full white drives the boosted channels into the clamp
        if (i == 0) begin
          r = 32'h00FF_FFFF;
        end else begin
          take_bits(24, r);
        end
        video_in.de  = 1'b1;
        video_in.rgb = r[23:0];
        next_cycle();
        exp.pixel.r = corrected(r[23:16], corr_gain_r, k);
        exp.pixel.g = corrected(r[15:8], corr_gain_g, k);
        exp.pixel.b = corrected(r[7:0], corr_gain_b, k);
        check_bit("video_out.de", 1'b1, video_out.de);
        check_video_word("video_out.word", exp, video_out.word);
      end
      video_in.de = 1'b0;
      next_cycle();
    end
    end_test("colour correction");
  endtask

  task automatic test_line_end();
    logic [31:0] r;
    logic        sq;
    video_word_u exp;
    begin_test();
    for (int frame = 0; frame < 2; frame++) begin
      if (frame == 0) begin
        take_bits(1, r);
        sq = r[0];
      end else begin
        // other pixel shape on the second frame
        sq = ~sq;
      end
      write_bridge(addr_square_pixels, {31'd0, sq});
      // frame height is taken at vsync start only
      video_in.vs         = 1'b1;
      video_in.hs         = 1'b1;
      video_in.tall_frame = (frame == 0);
      next_cycle();
      check_bit("video_out.vs", 1'b1, video_out.vs);
      check_bit("video_out.hs", 1'b1, video_out.hs);
      video_in.vs         = 1'b0;
      video_in.hs         = 1'b0;
      video_in.tall_frame = (frame != 0);
      next_cycle();
      check_bit("video_out.vs", 1'b0, video_out.vs);
      check_bit("video_out.hs", 1'b0, video_out.hs);
      repeat (4) begin
        take_bits(24, r);
        video_in.de  = 1'b1;
        video_in.rgb = r[23:0];
        next_cycle();
      end
      video_in.de = 1'b0;
      next_cycle();
      exp                    = '0;
      exp.ctrl.tall_frame_n  = (frame != 0);
      exp.ctrl.square_pixels = sq;
      check_bit("video_out.de", 1'b0, video_out.de);
      check_video_word("video_out.word", exp, video_out.word);
      repeat (3) begin
        next_cycle();
        check_video_word("video_out.word", exp, video_out.word);
      end
    end
    end_test("end-of-line word");
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    clk_74a         = 1'b0;
    pll_core_locked = 1'b1;
    bridge_in       = '0;
    cont1_key       = '0;
    cont1_joy       = 32'h0000_8080;
    video_in        = '0;
    lfsr_state      = 32'h230d;
    cycle_count     = 0;
    err_count       = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    exp_cart        = '0;
    exp_core        = '0;
    // falling edge starts the reset
    #1 pll_core_locked = 1'b0;
    repeat (5) @(posedge clk_74a);
    #1 pll_core_locked = 1'b1;
    test_reset();
    test_settings();
    test_reset_pulse();
    test_deadzone();
    test_color();
    test_line_end();
    $display("tests passed %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_passed, tests_failed, err_count,
             u_snes_host_top.u_snes_host_sva.fail_count);
    if (tests_failed == 0 && u_snes_host_top.u_snes_host_sva.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= max_cycles);
    $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* snes_host_top.f */
source/snes_host_pkg.sv
source/bridge_settings.sv
source/stick_deadzone.sv
source/video_color_out.sv
source/snes_host_top.sv
testbench/snes_host_sva.sv
testbench/snes_host_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := snes_host_tb
RTL_TOP    := snes_host_top
FILELIST   := snes_host_top.f
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

RTL_FILES  := $(filter source/%,$(shell cat $(FILELIST)))

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
